/* verilog.f */
lsu_pkg.sv
lsu_request.sv
lsu_txn_queue.sv
lsu_rdata_align.sv
lsu_top.sv
tb_data_mem.sv
tb_lsu.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --assert --timescale 1ns/1ps -j 0
TOP      := tb_lsu
FILELIST := verilog.f
OBJ_DIR  := obj_dir

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* tb_lsu.sv */
// Load/store unit testbench: random accesses checked against a byte-level memory model
module tb_lsu import lsu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH      = 2;
  localparam int SEED       = 32'hc986dd97;
  localparam int N_DIRECT   = 16;                         // 8 word stores, 8 loads
  localparam int N_RANDOM   = 400;
  localparam int MAX_CYCLES = (N_DIRECT + N_RANDOM) * 40;
  localparam int ERR_WORD   = 63;                         // Top word of the region

  typedef struct packed {
    logic        load;
    logic        err;
    word_t       rdata;
    word_t       addr;
    logic [15:0] idx;                                     // Access number
  } expect_t;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     req_valid_i;
  lsu_req_t req_i;
  logic     req_ready_o;
  logic     bus_req_o;
  bus_req_t bus_o;
  logic     bus_gnt_i;
  logic     bus_rvalid_i;
  bus_rsp_t bus_rsp_i;
  logic     rsp_valid_o;
  lsu_rsp_t rsp_o;
  logic     busy_o;

  int         seed = SEED;
  logic [7:0] model [256];                                // Byte image of the region
  expect_t    exp_q [$];                                  // Responses still due, in order
  int         exp_grants;
  int         grant_cnt;
  int         outstanding;                                // Grants minus responses
  int         cycle_cnt;
  logic       accepted_q;                                 // Handshake seen at last edge

  always #20 clk = ~clk;

  lsu_top #(.DEPTH(DEPTH)) lsu_top_inst (.*);

  tb_data_mem #(.ERR_WORD(ERR_WORD), .SEED(SEED)) tb_data_mem_inst (
    .clk, .rst_n, .bus_req_i(bus_req_o), .bus_i(bus_o), .bus_gnt_o(bus_gnt_i),
    .bus_rvalid_o(bus_rvalid_i), .bus_rsp_o(bus_rsp_i));

  ////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////

  task automatic stop_on_failure(string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at first failure");
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp)
      stop_on_failure($sformatf("Error %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_addr(string name, word_t exp, word_t act);
    if (act !== exp)
      stop_on_failure($sformatf("Error %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_err(string name, logic exp, logic act);
    if (act !== exp)
      stop_on_failure($sformatf("Error %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_busy(string name, logic exp, logic act);
    if (act !== exp)
      stop_on_failure($sformatf("Error %s expected %b actual %b", name, exp, act));
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Same fill pattern as the memory model
  function automatic logic [7:0] fill_byte(int unsigned a);
    return 8'(a * 151 + 19);
  endfunction

  function automatic int size_bytes(lsu_size_e s);
    if (s == SIZE_BYTE)
      return 1;
    return (s == SIZE_HALF) ? 2 : 4;
  endfunction

  // Crosses a word boundary, so two bus transfers
  function automatic logic is_split(lsu_size_e s, logic [7:0] a);
    return (s == SIZE_WORD && a[1:0] != 2'b00) || (s == SIZE_HALF && a[1:0] == 2'b11);
  endfunction

  // Predict, drive, then wait for the handshake
  task automatic do_access(logic we, lsu_size_e size, logic sx, logic incr,
                           logic [7:0] a, word_t wdata, int idx);
    word_t      opb;
    word_t      data;
    logic       err;
    logic [7:0] ba;
    int         n;
    expect_t    e;
    opb  = $random(seed);
    n    = size_bytes(size);
    err  = 1'b0;
    data = '0;
    for (int k = 0; k < n; k++)
    begin
      ba = a + 8'(k);                                     // Little endian
      if (ba[7:2] == 6'(ERR_WORD))
        err = 1'b1;                                       // Error word drops writes
      else if (we)
        model[ba] = 8'(wdata >> (8 * k));
      if (!we)
        data = data | (word_t'(model[ba]) << (8 * k));
    end
    if (!we && sx && n < 4 && ((data >> (8 * n - 1)) & 32'd1) != 0)
      data = data | (32'hffffffff << (8 * n));            // Sign extend
    req_i.we       = we;
    req_i.size     = size;
    req_i.sign_ext = sx;
    req_i.use_incr = incr;
    req_i.op_a     = incr ? word_t'(a) - opb : word_t'(a); // Sum wraps back to a
    req_i.op_b     = opb;
    req_i.wdata    = wdata;
    req_valid_i    = 1'b1;
    e.load  = !we;
    e.err   = err;
    e.rdata = data;
    e.addr  = word_t'(a);
    e.idx   = 16'(idx);
    exp_q.push_back(e);
    exp_grants += is_split(size, a) ? 2 : 1;
    do @(negedge clk); while (!accepted_q);
    if (grant_cnt != exp_grants)
      stop_on_failure($sformatf("Access %0d: %0d bus grants so far, %0d expected",
                                idx, grant_cnt, exp_grants));
    req_valid_i = 1'b0;
  endtask

  task automatic run_random(int count);
    word_t      r;
    lsu_size_e  size;
    logic [7:0] a;
    int         n;
    for (int i = 0; i < count; i++)
    begin
      r    = $random(seed);
      size = (r[1:0] == 2'b00) ? SIZE_BYTE : (r[1:0] == 2'b01) ? SIZE_HALF : SIZE_WORD;
      a    = (r[12:9] == 4'h0) ? {5'b11111, r[7:5]} : r[15:8];   // Bias toward error word
      n    = size_bytes(size);
      if (int'(a) + n > 256)
        a = 8'(256 - n);                                  // Stay inside the region
      do_access(r[16], size, r[17], r[18], a, $random(seed), N_DIRECT + i);
      if (r[22:21] == 2'b00)
        @(negedge clk);                                   // Idle gap
    end
  endtask

  ////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      accepted_q <= 1'b0;
    else
      accepted_q <= req_valid_i && req_ready_o;
  end

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      grant_cnt   = 0;
      outstanding = 0;
      cycle_cnt   = 0;
    end
    else
    begin
      cycle_cnt++;
      // Busy while transfers are outstanding or one is granted now
      check_busy($sformatf("cycle %0d busy", cycle_cnt),
                 (outstanding != 0) || (bus_req_o && bus_gnt_i), busy_o);
      if (bus_req_o && bus_gnt_i)
      begin
        grant_cnt++;
        outstanding++;
      end
      if (bus_rvalid_i)
        outstanding--;
      if (outstanding > DEPTH)
        stop_on_failure($sformatf("More than %0d bus transfers outstanding", DEPTH));
      if (cycle_cnt > MAX_CYCLES)
        stop_on_failure($sformatf("Timeout after %0d cycles", MAX_CYCLES));
    end
  end

  // Responses must come back in access order
  always @(posedge clk)
  begin
    expect_t e;
    if (rst_n && rsp_valid_o)
    begin
      if (exp_q.size() == 0)
        stop_on_failure("Core response with no access outstanding");
      e = exp_q.pop_front();
      check_addr($sformatf("access %0d addr", e.idx), e.addr, rsp_o.addr);
      check_err($sformatf("access %0d err", e.idx), e.err, rsp_o.err);
      if (e.load && !e.err)
        check_word($sformatf("access %0d rdata", e.idx), e.rdata, rsp_o.rdata);
    end
  end

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial
  begin
    rst_n       = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    exp_grants  = 0;
    for (int a = 0; a < 256; a++)
      model[8'(a)] = fill_byte(a);
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    repeat (4)
    begin
      @(negedge clk);
      if (bus_req_o || rsp_valid_o || req_ready_o || busy_o)
        stop_on_failure("Request, response, ready or busy raised with no stimulus");
    end
    for (int i = 0; i < 8; i++)
      do_access(1'b1, SIZE_WORD, 1'b0, i[0], 8'(4 * i), $random(seed), i);
    for (int i = 0; i < 8; i++)
      do_access(1'b0, SIZE_WORD, 1'b0, i[1], 8'(4 * i), '0, 8 + i);
    run_random(N_RANDOM);
    while (exp_q.size() != 0)
      @(negedge clk);                                     // Wait for the last response
    @(negedge clk);
    if (busy_o)
      stop_on_failure("busy_o still high after the final response");
    else
    begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

/* tb_data_mem.sv */
// Bus slave memory for the testbench: random grant and response delays, one error word
module tb_data_mem import lsu_pkg::*; #(
  parameter int ERR_WORD = 63,    // Answers with err, drops writes
  parameter int SEED     = 1
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     bus_req_i,
  input  bus_req_t bus_i,
  output logic     bus_gnt_o,
  output logic     bus_rvalid_o,
  output bus_rsp_t bus_rsp_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_PEND = 4;    // Responses queued at most

  word_t    mem [64];             // 256-byte region
  bus_rsp_t rsp_q [$];
  int       due_q [$];            // Earliest cycle for each response
  int       seed = SEED;
  int       cyc;
  int       gnt_wait;             // Cycles left before the next grant
  logic     gnt_q = 1'b0;
  logic     rvalid_q = 1'b0;
  bus_rsp_t rsp_out = '0;

  assign bus_gnt_o    = gnt_q;
  assign bus_rvalid_o = rvalid_q;
  assign bus_rsp_o    = rsp_out;

  function automatic logic [7:0] fill_byte(int unsigned a);
    return 8'(a * 151 + 19);
  endfunction

  initial
  begin
    for (int w = 0; w < 64; w++)
      mem[6'(w)] = {fill_byte(4 * w + 3), fill_byte(4 * w + 2),
                    fill_byte(4 * w + 1), fill_byte(4 * w)};
  end

  // Accept on grant, sent back in order after 1 to 4 cycles
  always @(posedge clk or negedge rst_n)
  begin
    logic [5:0] idx;
    word_t      mask;
    bus_rsp_t   rsp;
    if (!rst_n)
    begin
      rsp_q.delete();
      due_q.delete();
      cyc      = 0;
      gnt_wait = 0;
    end
    else
    begin
      if (rvalid_q)
      begin
        void'(rsp_q.pop_front());
        void'(due_q.pop_front());
      end
      if (bus_req_i && gnt_q)
      begin
        idx       = bus_i.addr[7:2];
        mask      = {{8{bus_i.be[3]}}, {8{bus_i.be[2]}}, {8{bus_i.be[1]}}, {8{bus_i.be[0]}}};
        rsp.err   = (int'(idx) == ERR_WORD);
        rsp.rdata = bus_i.we ? '0 : mem[idx];
        if (bus_i.we && !rsp.err)
          mem[idx] = (mem[idx] & ~mask) | (bus_i.wdata & mask);
        rsp_q.push_back(rsp);
        due_q.push_back(cyc + 1 + int'($unsigned($random(seed)) % 4));
        gnt_wait = int'($unsigned($random(seed)) % 4);    // 0 to 3
      end
      else if (bus_req_i && gnt_wait > 0)
        gnt_wait--;
      cyc++;
    end
  end

  // Outputs change on the falling edge only
  always @(negedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      gnt_q    <= 1'b0;
      rvalid_q <= 1'b0;
      rsp_out  <= '0;
    end
    else
    begin
      gnt_q    <= (gnt_wait == 0) && (rsp_q.size() < MAX_PEND);
      rvalid_q <= 1'b0;
      rsp_out  <= '0;
      if (rsp_q.size() != 0)
      begin
        rvalid_q <= (cyc >= due_q[0]);
        rsp_out  <= rsp_q[0];
      end
    end
  end

endmodule

/* lsu_top.sv */
// Load/store unit top level joining request side, transfer queue and read-data aligner
module lsu_top import lsu_pkg::*; #(
  parameter int DEPTH = 2                 // Max outstanding bus transfers
) (
  input  logic     clk,
  input  logic     rst_n,

  // Core request
  input  logic     req_valid_i,
  input  lsu_req_t req_i,
  output logic     req_ready_o,

  // Bus request
  output logic     bus_req_o,
  output bus_req_t bus_o,
  input  logic     bus_gnt_i,

  // Bus response
  input  logic     bus_rvalid_i,
  input  bus_rsp_t bus_rsp_i,

  // Core response
  output logic     rsp_valid_o,
  output lsu_rsp_t rsp_o,

  output logic     busy_o
);

  logic      q_full;   // No room for another outstanding transfer
  logic      q_push;   // Transfer granted this cycle
  txn_attr_t q_attr;   // Attributes of the granted transfer
  txn_attr_t q_head;   // Oldest outstanding transfer

  // Address, byte enables, split sequencing
  lsu_request #(
    .DEPTH       (DEPTH)
  ) lsu_request_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .full_i      (q_full),
    .bus_gnt_i   (bus_gnt_i),
    .req_ready_o (req_ready_o),
    .bus_req_o   (bus_req_o),
    .bus_o       (bus_o),
    .push_o      (q_push),
    .attr_o      (q_attr)
  );

  // One entry per granted transfer, popped by its response
  lsu_txn_queue #(
    .DEPTH   (DEPTH)
  ) lsu_txn_queue_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (q_push),
    .attr_i  (q_attr),
    .pop_i   (bus_rvalid_i),
    .head_o  (q_head),
    .full_o  (q_full),
    .busy_o  (busy_o)
  );

  // Response side, combinational from bus_rvalid_i
  lsu_rdata_align lsu_rdata_align_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_rsp_i    (bus_rsp_i),
    .head_i       (q_head),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o)
  );

endmodule

/* lsu_rdata_align.sv */
// Read-data aligner: extension, split-load assembly and core response generation
module lsu_rdata_align import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      bus_rvalid_i,
  input  bus_rsp_t  bus_rsp_i,
  input  txn_attr_t head_i,      // Attributes of the responding transfer
  output logic      rsp_valid_o,
  output lsu_rsp_t  rsp_o
);

  word_t       rdata;            // Raw bus data
  word_t       rdata_q;          // First-phase word of a split load
  logic        err_q;            // Error seen on a first phase
  logic [15:0] half_raw;
  logic [7:0]  byte_raw;
  word_t       rdata_w_ext;
  word_t       rdata_h_ext;
  word_t       rdata_b_ext;
  word_t       rdata_ext;

  assign rdata = bus_rsp_i.rdata;

  ////////////////////////////////////////
  // Word, halfword and byte views
  ////////////////////////////////////////

  // Upper bytes of the first word, then low bytes of the second
  always_comb
  begin
    case (head_i.offset)
      2'b00:   rdata_w_ext = rdata;
      2'b01:   rdata_w_ext = {rdata[7:0],  rdata_q[31:8]};
      2'b10:   rdata_w_ext = {rdata[15:0], rdata_q[31:16]};
      default: rdata_w_ext = {rdata[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb
  begin
    case (head_i.offset)
      2'b00:   half_raw = rdata[15:0];
      2'b01:   half_raw = rdata[23:8];
      2'b10:   half_raw = rdata[31:16];
      default: half_raw = {rdata[7:0], rdata_q[31:24]};  // Split halfword
    endcase
  end

  assign byte_raw = rdata[{head_i.offset, 3'b000} +: 8];

  assign rdata_h_ext = {{16{head_i.sign_ext & half_raw[15]}}, half_raw};
  assign rdata_b_ext = {{24{head_i.sign_ext & byte_raw[7]}}, byte_raw};

  always_comb
  begin
    case (head_i.size)
      SIZE_BYTE: rdata_ext = rdata_b_ext;
      SIZE_HALF: rdata_ext = rdata_h_ext;
      default:   rdata_ext = rdata_w_ext;
    endcase
  end

  ////////////////////////////////////////
  // First-phase state
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (bus_rvalid_i && !head_i.last && !head_i.we)
      rdata_q <= rdata;          // Raw, assembled on the second response
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      err_q <= 1'b0;
    else if (bus_rvalid_i)
    begin
      if (head_i.last)
        err_q <= 1'b0;           // Access done
      else
        err_q <= err_q | bus_rsp_i.err;
    end
  end

  ////////////////////////////////////////
  // Core response
  ////////////////////////////////////////

  assign rsp_valid_o = bus_rvalid_i && head_i.last;  // One pulse per access
  assign rsp_o.rdata = rdata_ext;                    // Don't care for stores
  assign rsp_o.err   = bus_rsp_i.err | err_q;        // Either half of a split
  assign rsp_o.addr  = head_i.addr;

endmodule

/* lsu_txn_queue.sv */
// In-order queue of attributes for outstanding bus transfers, with full and busy flags
module lsu_txn_queue import lsu_pkg::*; #(
  parameter int DEPTH = 2
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      push_i,      // Transfer granted
  input  txn_attr_t attr_i,
  input  logic      pop_i,       // Response for the head entry
  output txn_attr_t head_o,
  output logic      full_o,
  output logic      busy_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  txn_attr_t mem [DEPTH];        // Attribute storage
  ptr_t      wr_ptr_q;
  ptr_t      rd_ptr_q;
  cnt_t      cnt_q;              // Outstanding transfers

  // Wrap at DEPTH, which need not be a power of two
  function automatic ptr_t ptr_inc(ptr_t p);
    if (p == ptr_t'(DEPTH - 1))
      return '0;
    return p + 1'b1;
  endfunction

  always_ff @(posedge clk)
  begin
    if (push_i)
      mem[wr_ptr_q] <= attr_i;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_i)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;           // Both or neither
      endcase
    end
  end

  assign head_o = mem[rd_ptr_q];
  assign full_o = (cnt_q == cnt_t'(DEPTH));
  assign busy_o = (cnt_q != '0) || push_i; // Includes a transfer being granted now

  // Request side must honour full
  assert property (@(posedge clk) disable iff (!rst_n) !(push_i && full_o))
    else $error("lsu_txn_queue: push while full");

  // Every response needs a granted transfer ahead of it
  assert property (@(posedge clk) disable iff (!rst_n) !(pop_i && cnt_q == '0))
    else $error("lsu_txn_queue: response with nothing outstanding");

endmodule

/* lsu_request.sv */
// Load/store request side: address, split sequencing, byte enables and lane rotation
module lsu_request import lsu_pkg::*; #(
  parameter int DEPTH = 2
) (
  input  logic      clk,
  input  logic      rst_n,

  input  logic      req_valid_i,
  input  lsu_req_t  req_i,
  input  logic      full_i,       // Queue holds DEPTH transfers
  input  logic      bus_gnt_i,

  output logic      req_ready_o,
  output logic      bus_req_o,
  output bus_req_t  bus_o,
  output logic      push_o,
  output txn_attr_t attr_o
);

  typedef enum logic {
    PHASE_FIRST,                  // Only transfer, or lower part of a split
    PHASE_SECOND                  // Upper part of a split, next word
  } phase_e;

  phase_e  phase_q;
  phase_e  phase_d;
  word_t   addr;                  // Original access address
  offset_t offset;
  logic    misaligned;            // Access crosses a word boundary
  be_t     be;
  word_t   wdata_rot;

  // Queue sizing is only legal from one entry up
  if (DEPTH < 1)
  begin : g_depth_check
    $error("lsu_request: DEPTH must be at least 1");
  end

  ////////////////////////////////////////
  // Address and split detection
  ////////////////////////////////////////

  assign addr   = req_i.use_incr ? req_i.op_a + req_i.op_b : req_i.op_a;
  assign offset = addr[1:0];

  always_comb
  begin
    misaligned = 1'b0;
    case (req_i.size)
      SIZE_WORD: misaligned = (offset != 2'b00);
      SIZE_HALF: misaligned = (offset == 2'b11);  // Only offset 3 spills over
      default:   misaligned = 1'b0;               // Bytes never split
    endcase
  end

  ////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////

  always_comb
  begin
    be = 4'b0000;
    if (phase_q == PHASE_FIRST)
    begin
      case (req_i.size)
        SIZE_BYTE: be = 4'b0001 << offset;
        SIZE_HALF: be = (offset == 2'b11) ? 4'b1000 : 4'b0011 << offset;
        default:   be = 4'b1111 << offset;        // Lanes from offset up to 3
      endcase
    end
    else
    begin
      // Remaining bytes land in the low lanes of the next word
      case (req_i.size)
        SIZE_HALF: be = 4'b0001;
        default:   be = ~(4'b1111 << offset);     // Lanes below the offset
      endcase
    end
  end

  // Byte i of the store goes to lane (offset + i) mod 4
  always_comb
  begin
    case (offset)
      2'b00: wdata_rot = req_i.wdata;
      2'b01: wdata_rot = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10: wdata_rot = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata_rot = {req_i.wdata[7:0], req_i.wdata[31:8]};
    endcase
  end

  ////////////////////////////////////////
  // Bus request and queue push
  ////////////////////////////////////////

  assign bus_req_o = req_valid_i && !full_i;     // Held off while DEPTH outstanding
  assign push_o    = bus_req_o && bus_gnt_i;

  always_comb
  begin
    bus_o.addr  = addr;
    if (phase_q == PHASE_SECOND)
      bus_o.addr = {addr[31:2] + 30'd1, 2'b00};  // Word aligned, next word
    bus_o.we    = req_i.we;
    bus_o.be    = be;
    bus_o.wdata = wdata_rot;
  end

  assign attr_o.we       = req_i.we;
  assign attr_o.size     = req_i.size;
  assign attr_o.sign_ext = req_i.sign_ext;
  assign attr_o.offset   = offset;
  assign attr_o.last     = (phase_q == PHASE_SECOND) || !misaligned;
  assign attr_o.addr     = addr;                  // Reported with errors

  // Core is released with the grant of the final transfer
  assign req_ready_o = push_o && attr_o.last;

  ////////////////////////////////////////
  // Split FSM
  ////////////////////////////////////////

  always_comb
  begin
    phase_d = phase_q;
    if (push_o)
      phase_d = attr_o.last ? PHASE_FIRST : PHASE_SECOND;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      phase_q <= PHASE_FIRST;
    else
      phase_q <= phase_d;
  end

  // OBI: address phase may not change until granted
  assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_o && !bus_gnt_i |=> bus_req_o && $stable(bus_o))
    else $error("lsu_request: bus request changed before grant");

  // Core keeps its request up across both halves of a split
  assert property (@(posedge clk) disable iff (!rst_n)
    phase_q == PHASE_SECOND |-> req_valid_i)
    else $error("lsu_request: request dropped during split access");

endmodule

/* lsu_pkg.sv */
// Load/store unit shared types: widths, access sizes, core and bus structs
package lsu_pkg;

  ////////////////////////////////////////
  // Plain vector types
  ////////////////////////////////////////

  typedef logic [31:0] word_t;    // Data or address word
  typedef logic [3:0]  be_t;      // One enable per byte lane
  typedef logic [1:0]  offset_t;  // Byte offset within a word

  // Access size, encoded as in the core's decoder
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  ////////////////////////////////////////
  // Core side
  ////////////////////////////////////////

  typedef struct packed {
    logic      we;        // Store when set
    lsu_size_e size;
    logic      sign_ext;  // Sign extend narrow loads
    logic      use_incr;  // Address is op_a + op_b
    word_t     op_a;
    word_t     op_b;
    word_t     wdata;     // Store data, right aligned
  } lsu_req_t;

  typedef struct packed {
    word_t rdata;         // Aligned and extended load data
    logic  err;           // Bus error on any transfer of the access
    word_t addr;          // Original access address
  } lsu_rsp_t;

  ////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////

  typedef struct packed {
    word_t addr;
    logic  we;
    be_t   be;
    word_t wdata;         // Already rotated onto the byte lanes
  } bus_req_t;

  typedef struct packed {
    word_t rdata;
    logic  err;
  } bus_rsp_t;

  // Bookkeeping for one outstanding bus transfer
  typedef struct packed {
    logic      we;
    lsu_size_e size;
    logic      sign_ext;
    offset_t   offset;    // Byte offset of the original access
    logic      last;      // Final or only transfer of the access
    word_t     addr;      // Original access address
  } txn_attr_t;

endpackage
